// File: sim.f
rtl/apb_pkg.sv
rtl/apb_arbiter.sv
rtl/apb_latency_scaler.sv
rtl/apb_scratch_ram.sv
rtl/apb_slow_mem_top.sv
verif/apb_slow_mem_tb.sv

// File: verif/apb_slow_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module apb_slow_mem_tb;
    import apb_pkg::*;

    localparam int scale_num       = 9;
    localparam int scale_frac_bits = 10;
    localparam int ram_words       = 256;
    localparam int wait_states     = 2;
    localparam int exp_latency     = (scale_num + 1) * wait_states + 3;

    localparam int port_core = 0;
    localparam int port_dbg  = 1;
    localparam int port_both = 2;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic [1:0]      port;
        logic            write;
        logic [31:0]     addr;
        logic [31:0]     wdata;
        logic [3:0]      strb;
        logic [31:0]     exp_rdata;
        logic            exp_err;
        logic [31:0]     exp_rdata_b;
        logic            exp_err_b;
    } row_t;

    logic        clock;
    logic        reset;
    apb_req_t    core_req;
    apb_req_t    dbg_req;
    apb_rsp_t    core_rsp;
    apb_rsp_t    dbg_rsp;

    row_t        rows[$];
    logic [31:0] ref_mem [ram_words];
    logic [31:0] lfsr_state;
    int          errors = 0;
    int          cyc = 0;
    int          limit = 0;
    int          last_granted = port_core;

    apb_slow_mem_top #(
        .scale_num       (scale_num),
        .scale_frac_bits (scale_frac_bits),
        .ram_words       (ram_words),
        .wait_states     (wait_states)
    ) i_dut (
        .clock    (clock),
        .reset    (reset),
        .core_req (core_req),
        .dbg_req  (dbg_req),
        .core_rsp (core_rsp),
        .dbg_rsp  (dbg_rsp)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("Run hung waiting for pready after %0d cycles", cyc);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus sources and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // Writes merge under the strobes, reads return the word, out of range is an error
    function automatic void model_access(input logic write, input logic [31:0] addr,
            input logic [31:0] wdata, input logic [3:0] strb,
            output logic [31:0] rdata, output logic err);
        logic [31:0] idx;
        err   = addr >= ram_words * 4;
        idx   = addr >> 2;
        rdata = '0;
        if (!err && write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (!err) begin
            rdata = ref_mem[idx];
        end
    endfunction

    // Contention rows send the debug port one word higher with inverted data
    task automatic add_row(input logic [8*12-1:0] name, input int port, input logic write,
            input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] strb);
        row_t        r;
        logic [31:0] rd;
        logic        err;
        r       = '0;
        r.name  = name;
        r.port  = port[1:0];
        r.write = write;
        r.addr  = addr;
        r.wdata = wdata;
        r.strb  = strb;
        model_access(write, addr, wdata, strb, rd, err);
        r.exp_rdata = rd;
        r.exp_err   = err;
        if (port == port_both) begin
            model_access(write, addr + 4, ~wdata, strb, rd, err);
            r.exp_rdata_b = rd;
            r.exp_err_b   = err;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row("core_wr", port_core, 1'b1, 32'h010, rand_word(), 4'hf);
        add_row("core_rd", port_core, 1'b0, 32'h010, 32'h0, 4'h0);
        add_row("dbg_wr", port_dbg, 1'b1, 32'h020, rand_word(), 4'hf);
        add_row("dbg_rd", port_dbg, 1'b0, 32'h020, 32'h0, 4'h0);
        add_row("dbg_rd_core", port_dbg, 1'b0, 32'h010, 32'h0, 4'h0);
        add_row("core_rd_dbg", port_core, 1'b0, 32'h020, 32'h0, 4'h0);
        add_row("full_wr", port_core, 1'b1, 32'h040, rand_word(), 4'hf);
        add_row("strb_wr_a", port_dbg, 1'b1, 32'h040, rand_word(), 4'b0101);
        add_row("strb_rd_a", port_core, 1'b0, 32'h040, 32'h0, 4'h0);
        add_row("strb_wr_b", port_core, 1'b1, 32'h040, rand_word(), 4'b1000);
        add_row("strb_rd_b", port_dbg, 1'b0, 32'h040, 32'h0, 4'h0);
        add_row("base_wr", port_core, 1'b1, 32'h000, rand_word(), 4'hf);
        add_row("top_wr", port_core, 1'b1, 32'h3fc, rand_word(), 4'hf);
        add_row("top_rd", port_dbg, 1'b0, 32'h3fc, 32'h0, 4'h0);
        // 0x400 would alias onto word 0 if the range check were missing
        add_row("oor_wr", port_core, 1'b1, 32'h400, rand_word(), 4'hf);
        add_row("oor_rd", port_core, 1'b0, 32'h400, 32'h0, 4'h0);
        add_row("oor_rd_far", port_dbg, 1'b0, 32'h8000_0000, 32'h0, 4'h0);
        add_row("after_oor", port_dbg, 1'b0, 32'h000, 32'h0, 4'h0);
        add_row("both_wr", port_both, 1'b1, 32'h100, rand_word(), 4'hf);
        add_row("both_rd", port_both, 1'b0, 32'h100, 32'h0, 4'h0);
        add_row("core_wr_mid", port_core, 1'b1, 32'h200, rand_word(), 4'hf);
        add_row("both_rd_2", port_both, 1'b0, 32'h100, 32'h0, 4'h0);
        add_row("both_wr_2", port_both, 1'b1, 32'h108, rand_word(), 4'hf);
        add_row("both_rd_3", port_both, 1'b0, 32'h108, 32'h0, 4'h0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check(input string what, input logic [63:0] expected,
            input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail %0s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    task automatic drive_port(input int port, input apb_req_t req);
        if (port == port_core) begin
            core_req <= req;
        end else begin
            dbg_req <= req;
        end
    endtask

    function automatic apb_rsp_t port_rsp(input int port);
        return (port == port_core) ? core_rsp : dbg_rsp;
    endfunction

    // Latency counts edges from the end of the setup cycle to the edge raising pready
    task automatic apb_transfer(input int port, input logic write, input logic [31:0] addr,
            input logic [31:0] wdata, input logic [3:0] strb,
            output logic [31:0] rdata, output logic err, output int done, output int latency);
        apb_req_t req;
        apb_rsp_t rsp;
        int       start;
        req        = '0;
        req.paddr  = addr;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.pwdata = wdata;
        req.pstrb  = strb;
        @(posedge clock);
        drive_port(port, req);
        @(negedge clock);
        start = cyc;
        @(posedge clock);
        req.penable = 1'b1;
        drive_port(port, req);
        do begin
            @(negedge clock);
            rsp = port_rsp(port);
        end while (!rsp.pready);
        done    = cyc;
        latency = cyc - start - 1;
        rdata   = rsp.prdata;
        err     = rsp.pslverr;
        @(posedge clock);
        drive_port(port, '0);
    endtask

    task automatic run_single(input row_t r);
        logic [31:0] rd;
        logic        err;
        int          done;
        int          lat;
        apb_transfer(r.port, r.write, r.addr, r.wdata, r.strb, rd, err, done, lat);
        check($sformatf("%0s prdata", r.name), r.exp_rdata, rd);
        check($sformatf("%0s pslverr", r.name), r.exp_err, err);
        check($sformatf("%0s latency", r.name), exp_latency, lat);
        last_granted = r.port;
    endtask

    task automatic run_contention(input row_t r);
        logic [31:0] rd_a;
        logic [31:0] rd_b;
        logic        err_a;
        logic        err_b;
        int          done_a;
        int          done_b;
        int          lat_a;
        int          lat_b;
        int          winner;
        fork
            apb_transfer(port_core, r.write, r.addr, r.wdata, r.strb,
                         rd_a, err_a, done_a, lat_a);
            apb_transfer(port_dbg, r.write, r.addr + 4, ~r.wdata, r.strb,
                         rd_b, err_b, done_b, lat_b);
        join
        winner = (done_a < done_b) ? port_core : port_dbg;
        check($sformatf("%0s core prdata", r.name), r.exp_rdata, rd_a);
        check($sformatf("%0s core pslverr", r.name), r.exp_err, err_a);
        check($sformatf("%0s dbg prdata", r.name), r.exp_rdata_b, rd_b);
        check($sformatf("%0s dbg pslverr", r.name), r.exp_err_b, err_b);
        check($sformatf("%0s winner", r.name), 1 - last_granted, winner);
        check($sformatf("%0s latency", r.name), exp_latency,
              (winner == port_core) ? lat_a : lat_b);
        // The loser is granted right after, so it is the last one served
        last_granted = 1 - winner;
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        core_req   = '0;
        dbg_req    = '0;
        lfsr_state = 32'h54e9_b34b;
        build_table();
        limit = rows.size() * 60 + 200;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check("reset core_rsp", '0, core_rsp);
        check("reset dbg_rsp", '0, dbg_rsp);
        foreach (rows[i]) begin
            if (rows[i].port == port_both) begin
                run_contention(rows[i]);
            end else begin
                run_single(rows[i]);
            end
        end
        $display("Done: %0d rows, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/apb_slow_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module apb_slow_mem_top #(
    parameter int scale_num       = 9,
    parameter int scale_frac_bits = 10,
    parameter int ram_words       = 256,
    parameter int wait_states     = 2
) (
    input  wire               clock,
    input  wire               reset,
    input  apb_pkg::apb_req_t core_req,
    input  apb_pkg::apb_req_t dbg_req,
    output apb_pkg::apb_rsp_t core_rsp,
    output apb_pkg::apb_rsp_t dbg_rsp
);
    import apb_pkg::*;

    apb_req_t bus_req;
    apb_rsp_t bus_rsp;
    apb_req_t dev_req;
    apb_rsp_t dev_rsp;

    // Two requesters share one bus
    apb_arbiter i_arbiter (
        .clock    (clock),
        .reset    (reset),
        .core_req (core_req),
        .dbg_req  (dbg_req),
        .bus_rsp  (bus_rsp),
        .core_rsp (core_rsp),
        .dbg_rsp  (dbg_rsp),
        .bus_req  (bus_req)
    );

    apb_latency_scaler #(
        .scale_num       (scale_num),
        .scale_frac_bits (scale_frac_bits)
    ) i_scaler (
        .clock   (clock),
        .reset   (reset),
        .bus_req (bus_req),
        .dev_rsp (dev_rsp),
        .bus_rsp (bus_rsp),
        .dev_req (dev_req)
    );

    apb_scratch_ram #(
        .ram_words   (ram_words),
        .wait_states (wait_states)
    ) i_ram (
        .clock   (clock),
        .reset   (reset),
        .dev_req (dev_req),
        .dev_rsp (dev_rsp)
    );

endmodule

`default_nettype wire

// File: rtl/apb_scratch_ram.sv
`timescale 1ns/10ps
`default_nettype none

module apb_scratch_ram #(
    parameter int ram_words   = 256,
    parameter int wait_states = 2
) (
    input  wire               clock,
    input  wire               reset,
    input  apb_pkg::apb_req_t dev_req,
    output apb_pkg::apb_rsp_t dev_rsp
);
    import apb_pkg::*;

    localparam int idx_width = (ram_words > 1) ? $clog2(ram_words) : 1;
    localparam int cnt_width = (wait_states > 0) ? $clog2(wait_states + 1) : 1;
    localparam logic [addr_width-1:0] byte_limit = addr_width'(ram_words * 4);

    logic [data_width-1:0] mem [ram_words];
    logic [cnt_width-1:0]  wait_cnt;
    logic                  access;
    logic                  ready;
    logic                  in_range;
    logic [idx_width-1:0]  idx;

    assign access   = dev_req.psel && dev_req.penable;
    assign ready    = access && (wait_cnt == cnt_width'(wait_states));
    assign in_range = dev_req.paddr < byte_limit;
    assign idx      = dev_req.paddr[idx_width+1:2];

    // Wait states counted through the access phase
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (ready && dev_req.pwrite && in_range) begin
            for (int b = 0; b < strb_width; b++) begin
                if (dev_req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= dev_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    assign dev_rsp.pready  = ready;
    assign dev_rsp.prdata  = (ready && !dev_req.pwrite && in_range) ? mem[idx] : '0;
    assign dev_rsp.pslverr = ready && !in_range;

    a_penable_needs_psel: assert property (
        @(posedge clock) disable iff (reset)
        dev_req.penable |-> dev_req.psel
    );

endmodule

`default_nettype wire

// File: rtl/apb_latency_scaler.sv
`timescale 1ns/10ps
`default_nettype none

module apb_latency_scaler #(
    parameter int scale_num       = 9,
    parameter int scale_frac_bits = 10
) (
    input  wire               clock,
    input  wire               reset,
    input  apb_pkg::apb_req_t bus_req,
    input  apb_pkg::apb_rsp_t dev_rsp,
    output apb_pkg::apb_rsp_t bus_rsp,
    output apb_pkg::apb_req_t dev_req
);
    import apb_pkg::*;

    // Added once per device wait cycle, in fixed point
    localparam logic [31:0] acc_step = 32'(scale_num) << scale_frac_bits;

    typedef enum logic [1:0] {
        st_idle,
        st_active,
        st_delay
    } state_t;

    state_t                state;
    logic [31:0]           acc;
    logic                  pready_q;
    logic [data_width-1:0] cap_prdata;
    logic                  cap_pslverr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Measure, then stretch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= st_idle;
            acc      <= '0;
            pready_q <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (bus_req.psel && !bus_req.penable) begin
                        state <= st_active;
                    end
                end
                st_active: begin
                    if (dev_rsp.pready) begin
                        // Integer part is scale_num times the wait count
                        acc   <= acc >> scale_frac_bits;
                        state <= st_delay;
                    end else begin
                        acc <= acc + acc_step;
                    end
                end
                st_delay: begin
                    if (pready_q) begin
                        pready_q <= 1'b0;
                        state    <= st_idle;
                    end else if (acc == '0) begin
                        pready_q <= 1'b1;
                    end else begin
                        acc <= acc - 32'd1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_active && dev_rsp.pready) begin
            cap_prdata  <= dev_rsp.prdata;
            cap_pslverr <= dev_rsp.pslverr;
        end
    end

    // Device side is parked for the whole stretch, pready cycle included
    always_comb begin
        dev_req = bus_req;
        if (state == st_delay) begin
            dev_req.psel    = 1'b0;
            dev_req.penable = 1'b0;
        end
    end

    assign bus_rsp.pready  = pready_q;
    assign bus_rsp.prdata  = pready_q ? cap_prdata : '0;
    assign bus_rsp.pslverr = pready_q && cap_pslverr;

    // The stretched completion must land while the bus still holds access
    a_pready_in_access: assert property (
        @(posedge clock) disable iff (reset)
        bus_rsp.pready |-> bus_req.psel && bus_req.penable
    );

endmodule

`default_nettype wire

// File: rtl/apb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module apb_arbiter (
    input  wire               clock,
    input  wire               reset,
    input  apb_pkg::apb_req_t core_req,
    input  apb_pkg::apb_req_t dbg_req,
    input  apb_pkg::apb_rsp_t bus_rsp,
    output apb_pkg::apb_rsp_t core_rsp,
    output apb_pkg::apb_rsp_t dbg_rsp,
    output apb_pkg::apb_req_t bus_req
);
    import apb_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t   state;
    logic     gnt_dbg;
    logic     last_dbg;
    logic     pick_dbg;
    apb_req_t sel_req;

    // Debug wins when alone, or when both ask and core won last time
    assign pick_dbg = dbg_req.psel && (!core_req.psel || !last_dbg);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant and phase sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= st_idle;
            gnt_dbg  <= 1'b0;
            last_dbg <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (core_req.psel || dbg_req.psel) begin
                        gnt_dbg  <= pick_dbg;
                        last_dbg <= pick_dbg;
                        state    <= st_setup;
                    end
                end
                st_setup: begin
                    state <= st_access;
                end
                st_access: begin
                    if (bus_rsp.pready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Phases are regenerated here and the master only supplies held fields
    assign sel_req = gnt_dbg ? dbg_req : core_req;

    always_comb begin
        bus_req = '0;
        if (state != st_idle) begin
            bus_req         = sel_req;
            bus_req.psel    = 1'b1;
            bus_req.penable = (state == st_access);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign core_rsp = (state == st_access && !gnt_dbg) ? bus_rsp : '0;
    assign dbg_rsp  = (state == st_access && gnt_dbg) ? bus_rsp : '0;

    // A port only completes during its own held access phase
    a_core_rsp_granted: assert property (
        @(posedge clock) disable iff (reset)
        core_rsp.pready |-> core_req.psel && core_req.penable
    );

    a_dbg_rsp_granted: assert property (
        @(posedge clock) disable iff (reset)
        dbg_rsp.pready |-> dbg_req.psel && dbg_req.penable
    );

endmodule

`default_nettype wire

// File: rtl/apb_pkg.sv
`default_nettype none

package apb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    parameter int addr_width = 32;
    parameter int data_width = 32;
    parameter int strb_width = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Requester to completer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [addr_width-1:0] paddr;
        logic                  psel;
        logic                  penable;
        // Carried through, not checked
        logic [2:0]            pprot;
        logic                  pwrite;
        logic [data_width-1:0] pwdata;
        logic [strb_width-1:0] pstrb;
    } apb_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Completer to requester
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                  pready;
        logic [data_width-1:0] prdata;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire
